/* burst_splitter.f */
src/bsplit_pkg.sv
src/burst_len_fifo.sv
src/ax_splitter.sv
src/b_merger.sv
src/r_last_gen.sv
src/burst_splitter.sv
dv/burst_splitter_props.sv
dv/burst_splitter_checker.sv
dv/burst_splitter_tb.sv

/* dv/burst_splitter_checker.sv */
// Watches every DUT port and compares against the splitting rules
// Port names follow the DUT so the testbench can connect by name
// Downstream responder must answer SLVERR or OKAY only

`timescale 1ns/1ns

module burst_splitter_checker import bsplit_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  ax_chan_t s_aw_i,
  input  logic     s_aw_valid_i,
  input  logic     s_aw_ready_o,
  input  ax_chan_t s_ar_i,
  input  logic     s_ar_valid_i,
  input  logic     s_ar_ready_o,
  input  w_chan_t  s_w_i,
  input  b_chan_t  s_b_o,
  input  logic     s_b_valid_o,
  input  logic     s_b_ready_i,
  input  r_chan_t  s_r_o,
  input  logic     s_r_valid_o,
  input  logic     s_r_ready_i,
  input  ax_chan_t m_aw_o,
  input  logic     m_aw_valid_o,
  input  logic     m_aw_ready_i,
  input  ax_chan_t m_ar_o,
  input  logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  input  w_chan_t  m_w_o,
  input  logic     m_w_valid_o,
  input  b_chan_t  m_b_i,
  input  logic     m_b_valid_i,
  input  logic     m_b_ready_o,
  input  logic     m_r_ready_o,
  output int       mism_count_o,
  output int       fail_count_o,
  output int       b_seen_o,
  output int       r_seen_o,
  output int       pending_o
);

  ax_chan_t        exp_aw_q[$];
  ax_chan_t        exp_ar_q[$];
  r_chan_t         exp_r_q[$];
  b_chan_t         exp_b_q[$];
  int              wlen_q[$];
  logic [ID_W-1:0] wid_q[$];
  int              b_cnt;
  logic            b_err;
  logic            reset_q;

  initial begin
    mism_count_o = 0;
    fail_count_o = 0;
    b_seen_o     = 0;
    r_seen_o     = 0;
    pending_o    = 0;
    b_cnt        = 0;
    b_err        = 1'b0;
    reset_q      = 1'b0;
  end

  // Beat i of a burst, as a single-beat request
  function automatic ax_chan_t beat_req(input ax_chan_t ax, input int i);
    ax_chan_t req;
    req     = ax;
    req.len = '0;
    if (ax.burst == BURST_INCR) begin
      req.addr = ax.addr + (ADDR_W'(i) << ax.size);
    end
    return req;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    if (exp !== got) begin
      $display("mismatch %s exp=%h got=%h", name, exp, got);
      mism_count_o++;
    end
  endtask

  task automatic compare_ax(input string chan, input ax_chan_t exp, input ax_chan_t got);
    compare_field({chan, ".id"}, 64'(exp.id), 64'(got.id));
    compare_field({chan, ".addr"}, 64'(exp.addr), 64'(got.addr));
    compare_field({chan, ".len"}, 64'(exp.len), 64'(got.len));
    compare_field({chan, ".size"}, 64'(exp.size), 64'(got.size));
    compare_field({chan, ".burst"}, 64'(exp.burst), 64'(got.burst));
  endtask

  task automatic check_idle(input string when);
    if (m_aw_valid_o || m_ar_valid_o || m_w_valid_o || s_b_valid_o || s_r_valid_o ||
        m_b_ready_o || m_r_ready_o) begin
      $display("a valid or downstream ready output is high %s reset", when);
      fail_count_o++;
    end
  endtask

  always @(posedge clk_i) begin : watch
    r_chan_t  exp_r;
    b_chan_t  exp_b;
    ax_chan_t req;
    if (reset_i) begin
      if (reset_q) begin
        check_idle("during");
      end
    end else begin
      if (reset_q) begin
        check_idle("right after");
      end

      // --------------------
      // Expectations from upstream requests
      // --------------------
      if (s_aw_valid_i && s_aw_ready_o) begin
        for (int i = 0; i <= int'(s_aw_i.len); i++) begin
          exp_aw_q.push_back(beat_req(s_aw_i, i));
        end
        wlen_q.push_back(int'(s_aw_i.len));
        wid_q.push_back(s_aw_i.id);
      end
      if (s_ar_valid_i && s_ar_ready_o) begin
        for (int i = 0; i <= int'(s_ar_i.len); i++) begin
          req = beat_req(s_ar_i, i);
          exp_ar_q.push_back(req);
          exp_r.id   = s_ar_i.id;
          exp_r.data = req.addr ^ 32'h5a5a5a5a;
          exp_r.resp = RESP_OKAY;
          exp_r.last = (i == int'(s_ar_i.len));
          exp_r_q.push_back(exp_r);
        end
      end

      // --------------------
      // Comparisons
      // --------------------
      if (m_aw_valid_o && m_aw_ready_i) begin
        if (exp_aw_q.size() == 0) begin
          $display("downstream AW request with no write burst outstanding");
          fail_count_o++;
        end else begin
          compare_ax("m_aw_o", exp_aw_q.pop_front(), m_aw_o);
        end
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (exp_ar_q.size() == 0) begin
          $display("downstream AR request with no read burst outstanding");
          fail_count_o++;
        end else begin
          compare_ax("m_ar_o", exp_ar_q.pop_front(), m_ar_o);
        end
      end
      if (m_w_valid_o) begin
        compare_field("m_w_o.last", 64'(1'b1), 64'(m_w_o.last));
        compare_field("m_w_o.data", 64'(s_w_i.data), 64'(m_w_o.data));
        compare_field("m_w_o.strb", 64'(s_w_i.strb), 64'(m_w_o.strb));
      end
      if (s_r_valid_o && s_r_ready_i) begin
        r_seen_o++;
        if (exp_r_q.size() == 0) begin
          $display("upstream R beat with no read beat expected");
          fail_count_o++;
        end else begin
          exp_r = exp_r_q.pop_front();
          compare_field("s_r_o.id", 64'(exp_r.id), 64'(s_r_o.id));
          compare_field("s_r_o.data", 64'(exp_r.data), 64'(s_r_o.data));
          compare_field("s_r_o.resp", 64'(exp_r.resp), 64'(s_r_o.resp));
          compare_field("s_r_o.last", 64'(exp_r.last), 64'(s_r_o.last));
        end
      end

      // Per-beat B responses fold into one expected B per burst
      if (m_b_valid_i && m_b_ready_o) begin
        if (wlen_q.size() == 0) begin
          $display("downstream B accepted with no write burst outstanding");
          fail_count_o++;
        end else begin
          b_err = b_err | (m_b_i.resp == RESP_SLVERR);
          b_cnt++;
          if (b_cnt == wlen_q[0] + 1) begin
            exp_b.id   = wid_q.pop_front();
            exp_b.resp = b_err ? RESP_SLVERR : RESP_OKAY;
            void'(wlen_q.pop_front());
            exp_b_q.push_back(exp_b);
            b_cnt = 0;
            b_err = 1'b0;
          end
        end
      end
      if (s_b_valid_o && s_b_ready_i) begin
        b_seen_o++;
        if (exp_b_q.size() == 0) begin
          $display("upstream B before all beats of its burst were answered");
          fail_count_o++;
        end else begin
          exp_b = exp_b_q.pop_front();
          compare_field("s_b_o.id", 64'(exp_b.id), 64'(s_b_o.id));
          compare_field("s_b_o.resp", 64'(exp_b.resp), 64'(s_b_o.resp));
        end
      end
    end
    reset_q   = reset_i;
    pending_o = exp_aw_q.size() + exp_ar_q.size() + exp_r_q.size() + exp_b_q.size() +
                wlen_q.size();
  end

endmodule

/* dv/burst_splitter_props.sv */
// Concurrent checks bound onto the burst splitter top level
// Needs a simulator run with assertions enabled

`timescale 1ns/1ns

module burst_splitter_props import bsplit_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input ax_chan_t m_aw_i,
  input logic     m_aw_valid_i,
  input logic     m_aw_ready_i,
  input ax_chan_t m_ar_i,
  input logic     m_ar_valid_i,
  input logic     m_ar_ready_i,
  input b_chan_t  s_b_i,
  input logic     s_b_valid_i,
  input logic     s_b_ready_i,
  input r_chan_t  s_r_i,
  input logic     s_r_valid_i,
  input logic     s_r_ready_i
);

  // A stalled downstream request holds its word and valid
  aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    m_aw_valid_i && !m_aw_ready_i |=> m_aw_valid_i && $stable(m_aw_i))
    else $error("downstream AW request changed while stalled");

  ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    m_ar_valid_i && !m_ar_ready_i |=> m_ar_valid_i && $stable(m_ar_i))
    else $error("downstream AR request changed while stalled");

  // A stalled response holds its word and valid
  b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    s_b_valid_i && !s_b_ready_i |=> s_b_valid_i && $stable(s_b_i))
    else $error("upstream B changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    s_r_valid_i && !s_r_ready_i |=> s_r_valid_i && $stable(s_r_i))
    else $error("upstream R changed while stalled");

endmodule

bind burst_splitter burst_splitter_props props_i (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .m_aw_i       (m_aw_o),
  .m_aw_valid_i (m_aw_valid_o),
  .m_aw_ready_i (m_aw_ready_i),
  .m_ar_i       (m_ar_o),
  .m_ar_valid_i (m_ar_valid_o),
  .m_ar_ready_i (m_ar_ready_i),
  .s_b_i        (s_b_o),
  .s_b_valid_i  (s_b_valid_o),
  .s_b_ready_i  (s_b_ready_i),
  .s_r_i        (s_r_o),
  .s_r_valid_i  (s_r_valid_o),
  .s_r_ready_i  (s_r_ready_i)
);

/* dv/burst_splitter_tb.sv */
// Drives a table of bursts into the splitter and models the downstream slave
// Downstream answers in order; R data is the address XOR 32'h5a5a5a5a
// Every handshake wait gives up after TIMEOUT cycles

`timescale 1ns/1ns

module burst_splitter_tb import bsplit_pkg::*; ();

  localparam int NUM_ROWS = 12;
  localparam int TIMEOUT = 4000;

  typedef struct {
    logic              is_wr;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [ADDR_W-1:0] err_addr;
    int                stall;
  } row_t;

  logic     clk_i;
  logic     reset_i;
  ax_chan_t s_aw_i;
  logic     s_aw_valid_i;
  logic     s_aw_ready_o;
  ax_chan_t s_ar_i;
  logic     s_ar_valid_i;
  logic     s_ar_ready_o;
  w_chan_t  s_w_i;
  logic     s_w_valid_i;
  logic     s_w_ready_o;
  b_chan_t  s_b_o;
  logic     s_b_valid_o;
  logic     s_b_ready_i = 1'b0;
  r_chan_t  s_r_o;
  logic     s_r_valid_o;
  logic     s_r_ready_i = 1'b0;
  ax_chan_t m_aw_o;
  logic     m_aw_valid_o;
  logic     m_aw_ready_i = 1'b0;
  ax_chan_t m_ar_o;
  logic     m_ar_valid_o;
  logic     m_ar_ready_i = 1'b0;
  w_chan_t  m_w_o;
  logic     m_w_valid_o;
  logic     m_w_ready_i = 1'b0;
  b_chan_t  m_b_i = '0;
  logic     m_b_valid_i = 1'b0;
  logic     m_b_ready_o;
  r_chan_t  m_r_i = '0;
  logic     m_r_valid_i = 1'b0;
  logic     m_r_ready_o;

  int mism_count_o;
  int fail_count_o;
  int b_seen_o;
  int r_seen_o;
  int pending_o;

  row_t rows [NUM_ROWS];
  int   seed = 32'h64cd047a;
  int   up_stall = 0;
  int   timeouts = 0;
  int   n_wr = 0;
  int   n_rbeats = 0;

  burst_splitter burst_splitter_i (.*);
  burst_splitter_checker checker_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic int roll_percent();
    return int'({$random(seed)} % 100);
  endfunction

  function automatic int next_write_row(input int from);
    for (int i = from; i < NUM_ROWS; i++) begin
      if (rows[i].is_wr) begin
        return i;
      end
    end
    return NUM_ROWS - 1;
  endfunction

  // --------------------
  // Downstream slave model
  // --------------------
  always begin : responder
    logic [ADDR_W-1:0] raddr_q[$];
    logic [ID_W-1:0]   rid_q[$];
    logic [1:0]        bresp_q[$];
    logic [ID_W-1:0]   bid_q[$];
    int                w_row;
    int                w_beat;
    int                w_in;
    logic              b_acc;
    logic              r_acc;
    w_row  = -1;
    w_beat = 0;
    w_in   = 0;
    forever begin
      b_acc = 1'b0;
      r_acc = 1'b0;
      @(posedge clk_i);
      if (!reset_i) begin
        if (m_aw_valid_o && m_aw_ready_i) begin
          if (w_beat == 0) begin
            w_row = next_write_row(w_row + 1);
          end
          bresp_q.push_back((m_aw_o.addr == rows[w_row].err_addr) ? RESP_SLVERR : RESP_OKAY);
          bid_q.push_back(m_aw_o.id);
          w_beat++;
          if (w_beat > int'(rows[w_row].len)) begin
            w_beat = 0;
          end
        end
        if (m_w_valid_o && m_w_ready_i) begin
          w_in++;
        end
        if (m_ar_valid_o && m_ar_ready_i) begin
          raddr_q.push_back(m_ar_o.addr);
          rid_q.push_back(m_ar_o.id);
        end
        b_acc = m_b_valid_i && m_b_ready_o;
        r_acc = m_r_valid_i && m_r_ready_o;
      end
      @(negedge clk_i);
      if (!reset_i) begin
        m_aw_ready_i = (roll_percent() >= 25);
        m_ar_ready_i = (roll_percent() >= 25);
        m_w_ready_i  = (roll_percent() >= 25);
        s_b_ready_i  = (roll_percent() >= up_stall);
        s_r_ready_i  = (roll_percent() >= up_stall);
        if (b_acc) begin
          m_b_valid_i = 1'b0;
        end
        // A B needs both its request and its data beat
        if (!m_b_valid_i && bresp_q.size() > 0 && w_in > 0 && roll_percent() >= 30) begin
          m_b_i.id    = bid_q.pop_front();
          m_b_i.resp  = bresp_q.pop_front();
          m_b_valid_i = 1'b1;
          w_in--;
        end
        if (r_acc) begin
          m_r_valid_i = 1'b0;
        end
        if (!m_r_valid_i && raddr_q.size() > 0 && roll_percent() >= 30) begin
          m_r_i.id    = rid_q.pop_front();
          m_r_i.data  = raddr_q.pop_front() ^ 32'h5a5a5a5a;
          m_r_i.resp  = RESP_OKAY;
          m_r_i.last  = 1'b1;
          m_r_valid_i = 1'b1;
        end
      end
    end
  end

  // --------------------
  // Upstream driver
  // --------------------
  // Called on a falling edge with valid already high, returns on a falling edge
  task automatic wait_accept(input int chan, input string what);
    int   cycles;
    logic ok;
    cycles = 0;
    ok     = 1'b0;
    while (!ok) begin
      @(posedge clk_i);
      case (chan)
        0: ok = s_aw_ready_o;
        1: ok = s_ar_ready_o;
        default: ok = s_w_ready_o;
      endcase
      cycles++;
      if (!ok && cycles > TIMEOUT) begin
        $display("timeout: no %s handshake after %0d cycles", what, cycles);
        timeouts++;
        ok = 1'b1;
      end
    end
    @(negedge clk_i);
  endtask

  task automatic send_row(input int r);
    row_t row;
    row      = rows[r];
    up_stall = row.stall;
    if (row.is_wr) begin
      s_aw_i       = '{row.id, row.addr, row.len, row.size, row.burst};
      s_aw_valid_i = 1'b1;
      wait_accept(0, "AW");
      s_aw_valid_i = 1'b0;
      for (int i = 0; i <= int'(row.len) && timeouts == 0; i++) begin
        s_w_i.data  = 32'hc0de0000 ^ (DATA_W'(r) << 12) ^ DATA_W'(i);
        s_w_i.strb  = STRB_W'(i * 3 + r);
        s_w_i.last  = (i == int'(row.len));
        s_w_valid_i = 1'b1;
        wait_accept(2, "W");
        s_w_valid_i = 1'b0;
      end
      n_wr++;
    end else begin
      s_ar_i       = '{row.id, row.addr, row.len, row.size, row.burst};
      s_ar_valid_i = 1'b1;
      wait_accept(1, "AR");
      s_ar_valid_i = 1'b0;
      n_rbeats += int'(row.len) + 1;
    end
  endtask

  initial begin : main
    int cycles;
    // dir, id, addr, len, size, burst, error address, upstream stall percent
    rows[0]  = '{1'b1, 4'h1, 32'h1000, 8'd0, 3'd2, BURST_INCR, 32'hffff_fff0, 0};
    rows[1]  = '{1'b0, 4'h2, 32'h2000, 8'd3, 3'd2, BURST_INCR, 32'hffff_fff0, 0};
    rows[2]  = '{1'b1, 4'h3, 32'h3000, 8'd7, 3'd2, BURST_INCR, 32'h0000_300c, 30};
    rows[3]  = '{1'b0, 4'h4, 32'h4000, 8'd5, 3'd2, BURST_FIXED, 32'hffff_fff0, 30};
    rows[4]  = '{1'b1, 4'h5, 32'h5000, 8'd4, 3'd1, BURST_FIXED, 32'h0000_5000, 50};
    rows[5]  = '{1'b0, 4'h6, 32'h6000, 8'd15, 3'd3, BURST_INCR, 32'hffff_fff0, 50};
    rows[6]  = '{1'b1, 4'h7, 32'h7000, 8'd15, 3'd2, BURST_INCR, 32'h0000_703c, 20};
    rows[7]  = '{1'b0, 4'h8, 32'h8000, 8'd0, 3'd2, BURST_INCR, 32'hffff_fff0, 20};
    rows[8]  = '{1'b1, 4'h9, 32'h9000, 8'd2, 3'd0, BURST_INCR, 32'hffff_fff0, 40};
    rows[9]  = '{1'b0, 4'ha, 32'ha000, 8'd255, 3'd2, BURST_INCR, 32'hffff_fff0, 10};
    rows[10] = '{1'b1, 4'hb, 32'hb000, 8'd255, 3'd2, BURST_INCR, 32'h0000_b200, 10};
    rows[11] = '{1'b1, 4'hc, 32'hc000, 8'd1, 3'd2, BURST_FIXED, 32'hffff_fff0, 0};

    reset_i      = 1'b1;
    s_aw_i       = '0;
    s_aw_valid_i = 1'b0;
    s_ar_i       = '0;
    s_ar_valid_i = 1'b0;
    s_w_i        = '0;
    s_w_valid_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (2) @(negedge clk_i);

    for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
      send_row(r);
    end

    // Drain the outstanding responses
    cycles = 0;
    while ((b_seen_o < n_wr || r_seen_o < n_rbeats) && timeouts == 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: responses still missing after %0d cycles", cycles);
        timeouts++;
      end
    end
    if (timeouts == 0 && pending_o != 0) begin
      $display("%0d expected requests or responses never appeared", pending_o);
      timeouts++;
    end

    $display("mismatches=%0d failures=%0d timeouts=%0d", mism_count_o, fail_count_o,
             timeouts);
    if (mism_count_o == 0 && fail_count_o == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the burst splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module burst_splitter_tb \
  -f burst_splitter.f \
  -o sim_burst_splitter
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_burst_splitter)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* src/ax_splitter.sv */
// Splits one AW or AR burst into len+1 single-beat requests
// Only INCR and FIXED bursts are expected; WRAP is treated as FIXED
// Single-beat requests fall through, longer bursts are stored first

`timescale 1ns/1ns

module ax_splitter import bsplit_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  ax_chan_t         ax_i,
  input  logic             ax_valid_i,
  output logic             ax_ready_o,
  output ax_chan_t         ax_o,
  output logic             ax_valid_o,
  input  logic             ax_ready_i,
  input  logic             full_i,
  output logic             push_o,
  output logic [LEN_W-1:0] push_len_o
);

  typedef enum logic {S_IDLE, S_BUSY} state_t;

  state_t   state_d;
  state_t   state_q;
  ax_chan_t ax_d;
  ax_chan_t ax_q;

  // Length is always taken from the burst being accepted
  assign push_len_o = ax_i.len;

  always_comb begin
    state_d    = state_q;
    ax_d       = ax_q;
    ax_o       = '0;
    ax_valid_o = 1'b0;
    ax_ready_o = 1'b0;
    push_o     = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (ax_valid_i && !full_i) begin
          ax_o       = ax_i;
          ax_o.len   = '0;
          ax_valid_o = 1'b1;
          if (ax_i.len == '0) begin
            // Nothing to split, handshake both sides together
            if (ax_ready_i) begin
              ax_ready_o = 1'b1;
              push_o     = 1'b1;
            end
          end else begin
            ax_ready_o = 1'b1;
            push_o     = 1'b1;
            ax_d       = ax_i;
            state_d    = S_BUSY;
            if (ax_ready_i) begin
              ax_d.len = ax_i.len - LEN_W'(1);
              if (ax_i.burst == BURST_INCR) begin
                ax_d.addr = ax_i.addr + (ADDR_W'(1) << ax_i.size);
              end
            end
          end
        end
      end
      S_BUSY: begin
        ax_o       = ax_q;
        ax_o.len   = '0;
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = S_IDLE;
          end else begin
            ax_d.len = ax_q.len - LEN_W'(1);
            if (ax_q.burst == BURST_INCR) begin
              ax_d.addr = ax_q.addr + (ADDR_W'(1) << ax_q.size);
            end
          end
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

endmodule

/* src/b_merger.sv */
// Merges the per-beat B responses of a write burst into one B
// Merged resp is SLVERR if any beat failed, else the last beat's resp
// The head burst is popped when the final B is seen, not when it is accepted

`timescale 1ns/1ns

module b_merger import bsplit_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  b_chan_t m_b_i,
  input  logic    m_b_valid_i,
  output logic    m_b_ready_o,
  output b_chan_t s_b_o,
  output logic    s_b_valid_o,
  input  logic    s_b_ready_i,
  input  logic    head_valid_i,
  input  logic    head_last_i,
  input  logic    head_err_i,
  output logic    beat_o,
  output logic    set_err_o
);

  typedef enum logic {S_READY, S_WAIT} state_t;

  state_t     state_d;
  state_t     state_q;
  logic [1:0] resp_q;
  logic [1:0] merged_resp;

  assign merged_resp = head_err_i ? RESP_SLVERR : m_b_i.resp;
  // Any error bit marks the burst as failed
  assign set_err_o   = beat_o & m_b_i.resp[1];

  always_comb begin
    state_d     = state_q;
    m_b_ready_o = 1'b0;
    s_b_o       = m_b_i;
    s_b_valid_o = 1'b0;
    beat_o      = 1'b0;
    case (state_q)
      S_READY: begin
        if (m_b_valid_i && head_valid_i) begin
          beat_o = 1'b1;
          if (!head_last_i) begin
            // Swallow intermediate responses
            m_b_ready_o = 1'b1;
          end else begin
            s_b_o.resp  = merged_resp;
            s_b_valid_o = 1'b1;
            if (s_b_ready_i) begin
              m_b_ready_o = 1'b1;
            end else begin
              state_d = S_WAIT;
            end
          end
        end
      end
      S_WAIT: begin
        s_b_o.resp  = resp_q;
        s_b_valid_o = 1'b1;
        if (s_b_ready_i) begin
          m_b_ready_o = 1'b1;
          state_d     = S_READY;
        end
      end
      default: begin
        state_d = S_READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_READY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_READY) begin
      resp_q <= merged_resp;
    end
  end

endmodule

/* src/bsplit_pkg.sv */
// Widths, limits, codes and channel words shared by the burst splitter
// No user, cache, prot or atop fields are carried on any channel
// MAX_TXNS must be a power of two so the queue pointers wrap by themselves

package bsplit_pkg;

  // --------------------
  // Bus widths and limits
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W = 4;
  localparam int LEN_W = 8;

  // Outstanding bursts per direction
  localparam int MAX_TXNS = 4;
  localparam int TXN_PTR_W = $clog2(MAX_TXNS);
  localparam int TXN_CNT_W = TXN_PTR_W + 1;

  // --------------------
  // Burst and response codes
  // --------------------
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // --------------------
  // Channel words
  // --------------------
  // Shared by AW and AR
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ax_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

endpackage

/* src/burst_len_fifo.sv */
// In-order queue of burst lengths, at most MAX_TXNS entries
// Beats must only be signalled while head_valid_o is high
// Pushes are dropped while full_o is high

`timescale 1ns/1ns

module burst_len_fifo import bsplit_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [LEN_W-1:0] push_len_i,
  input  logic             beat_i,
  input  logic             set_err_i,
  output logic             full_o,
  output logic             head_valid_o,
  output logic             head_last_o,
  output logic             head_err_o
);

  logic [LEN_W-1:0]     len_mem [MAX_TXNS];
  logic [TXN_PTR_W-1:0] wr_ptr_q;
  logic [TXN_PTR_W-1:0] rd_ptr_q;
  logic [TXN_PTR_W-1:0] rd_ptr_next;
  logic [TXN_CNT_W-1:0] count_q;
  logic [LEN_W-1:0]     rem_q;
  logic                 err_q;
  logic                 do_push;
  logic                 do_beat;
  logic                 do_pop;

  assign full_o       = (count_q == TXN_CNT_W'(MAX_TXNS));
  assign head_valid_o = (count_q != '0);
  assign head_last_o  = (rem_q == '0);
  // Error of the current beat counts at once
  assign head_err_o   = err_q | set_err_i;

  assign do_push     = push_i & ~full_o;
  assign do_beat     = beat_i & head_valid_o;
  assign do_pop      = do_beat & head_last_o;
  assign rd_ptr_next = rd_ptr_q + TXN_PTR_W'(1);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      len_mem[wr_ptr_q] <= push_len_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rem_q    <= '0;
      err_q    <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + TXN_PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_next;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + TXN_CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - TXN_CNT_W'(1);
      end

      // --------------------
      // Head beat counter
      // --------------------
      if (do_pop) begin
        // Next head is either already queued or arrives right now
        if (count_q > TXN_CNT_W'(1)) begin
          rem_q <= len_mem[rd_ptr_next];
        end else if (do_push) begin
          rem_q <= push_len_i;
        end
      end else if (do_beat) begin
        rem_q <= rem_q - LEN_W'(1);
      end else if (!head_valid_o && do_push) begin
        rem_q <= push_len_i;
      end

      // Sticky error, cleared for the next head
      if (do_pop) begin
        err_q <= 1'b0;
      end else if (set_err_i && do_beat) begin
        err_q <= 1'b1;
      end
    end
  end

endmodule

/* src/burst_splitter.sv */
// AXI4 burst splitter for a downstream bus with in-order responses
// Upstream must send INCR or FIXED bursts only, no atomics
// Up to MAX_TXNS bursts per direction may be outstanding

`timescale 1ns/1ns

module burst_splitter import bsplit_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Upstream side
  input  ax_chan_t s_aw_i,
  input  logic     s_aw_valid_i,
  output logic     s_aw_ready_o,
  input  ax_chan_t s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  input  w_chan_t  s_w_i,
  input  logic     s_w_valid_i,
  output logic     s_w_ready_o,
  output b_chan_t  s_b_o,
  output logic     s_b_valid_o,
  input  logic     s_b_ready_i,
  output r_chan_t  s_r_o,
  output logic     s_r_valid_o,
  input  logic     s_r_ready_i,
  // Downstream side
  output ax_chan_t m_aw_o,
  output logic     m_aw_valid_o,
  input  logic     m_aw_ready_i,
  output ax_chan_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  output w_chan_t  m_w_o,
  output logic     m_w_valid_o,
  input  logic     m_w_ready_i,
  input  b_chan_t  m_b_i,
  input  logic     m_b_valid_i,
  output logic     m_b_ready_o,
  input  r_chan_t  m_r_i,
  input  logic     m_r_valid_i,
  output logic     m_r_ready_o
);

  logic             w_push;
  logic [LEN_W-1:0] w_push_len;
  logic             w_full;
  logic             w_beat;
  logic             w_set_err;
  logic             w_head_valid;
  logic             w_head_last;
  logic             w_head_err;
  logic             r_push;
  logic [LEN_W-1:0] r_push_len;
  logic             r_full;
  logic             r_beat;
  logic             r_set_err;
  logic             r_head_valid;
  logic             r_head_last;

  // Reads never merge responses
  assign r_set_err = 1'b0;

  // --------------------
  // Write path
  // --------------------
  ax_splitter aw_splitter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ax_i       (s_aw_i),
    .ax_valid_i (s_aw_valid_i),
    .ax_ready_o (s_aw_ready_o),
    .ax_o       (m_aw_o),
    .ax_valid_o (m_aw_valid_o),
    .ax_ready_i (m_aw_ready_i),
    .full_i     (w_full),
    .push_o     (w_push),
    .push_len_o (w_push_len)
  );

  burst_len_fifo w_len_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (w_push),
    .push_len_i   (w_push_len),
    .beat_i       (w_beat),
    .set_err_i    (w_set_err),
    .full_o       (w_full),
    .head_valid_o (w_head_valid),
    .head_last_o  (w_head_last),
    .head_err_o   (w_head_err)
  );

  b_merger b_merger_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .m_b_i        (m_b_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .s_b_o        (s_b_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .head_valid_i (w_head_valid),
    .head_last_i  (w_head_last),
    .head_err_i   (w_head_err),
    .beat_o       (w_beat),
    .set_err_o    (w_set_err)
  );

  // Every W beat becomes a burst of its own
  always_comb begin
    m_w_o      = s_w_i;
    m_w_o.last = 1'b1;
  end
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  // --------------------
  // Read path
  // --------------------
  ax_splitter ar_splitter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ax_i       (s_ar_i),
    .ax_valid_i (s_ar_valid_i),
    .ax_ready_o (s_ar_ready_o),
    .ax_o       (m_ar_o),
    .ax_valid_o (m_ar_valid_o),
    .ax_ready_i (m_ar_ready_i),
    .full_i     (r_full),
    .push_o     (r_push),
    .push_len_o (r_push_len)
  );

  burst_len_fifo r_len_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (r_push),
    .push_len_i   (r_push_len),
    .beat_i       (r_beat),
    .set_err_i    (r_set_err),
    .full_o       (r_full),
    .head_valid_o (r_head_valid),
    .head_last_o  (r_head_last),
    .head_err_o   ()
  );

  r_last_gen r_last_gen_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .m_r_i        (m_r_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_o        (s_r_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .head_valid_i (r_head_valid),
    .head_last_i  (r_head_last),
    .beat_o       (r_beat)
  );

endmodule

/* src/r_last_gen.sv */
// Forwards R beats and rebuilds last from the head burst length
// A beat waits downstream until its burst length is queued

`timescale 1ns/1ns

module r_last_gen import bsplit_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  r_chan_t m_r_i,
  input  logic    m_r_valid_i,
  output logic    m_r_ready_o,
  output r_chan_t s_r_o,
  output logic    s_r_valid_o,
  input  logic    s_r_ready_i,
  input  logic    head_valid_i,
  input  logic    head_last_i,
  output logic    beat_o
);

  typedef enum logic {S_FEED, S_WAIT} state_t;

  state_t state_d;
  state_t state_q;
  logic   last_q;

  always_comb begin
    state_d     = state_q;
    m_r_ready_o = 1'b0;
    s_r_o       = m_r_i;
    s_r_o.last  = 1'b0;
    s_r_valid_o = 1'b0;
    beat_o      = 1'b0;
    case (state_q)
      S_FEED: begin
        if (m_r_valid_i && head_valid_i) begin
          s_r_o.last  = head_last_i;
          s_r_valid_o = 1'b1;
          // Count the beat now, the queue may move on while we wait
          beat_o      = 1'b1;
          if (s_r_ready_i) begin
            m_r_ready_o = 1'b1;
          end else begin
            state_d = S_WAIT;
          end
        end
      end
      S_WAIT: begin
        s_r_o.last  = last_q;
        s_r_valid_o = m_r_valid_i;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = S_FEED;
        end
      end
      default: begin
        state_d = S_FEED;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_FEED;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_FEED) begin
      last_q <= head_last_i;
    end
  end

endmodule
